//--- design/zpu_ctrl_cfg.svh
// Bus widths, register map and compatibility constants of the control block
// Included by the package and by the blocks that decode register addresses
`ifndef ZPU_CTRL_CFG_SVH
`define ZPU_CTRL_CFG_SVH

// Bus widths
`define ZPU_DW       32     // Settings and readback data word
`define ZPU_SB_ADDRW 8      // Register address

// Setting register addresses
`define SR_ZPU_SW_RST    8'd0
`define SR_ZPU_LEDS      8'd1
`define SR_ZPU_DEBUG     8'd2
`define SR_ZPU_SFP_CTRL0 8'd3
`define SR_ZPU_SFP_CTRL1 8'd4

// Readback addresses
// Address 4 and all addresses above 6 return zero
`define RB_ZPU_COMPAT       8'd0
`define RB_ZPU_COUNTER      8'd1
`define RB_ZPU_SFP_STATUS0  8'd2
`define RB_ZPU_SFP_STATUS1  8'd3
`define RB_ZPU_ETH0_PKT_CNT 8'd5
`define RB_ZPU_ETH1_PKT_CNT 8'd6

// Compatibility word fields from the most significant down
`define ZPU_PRODUCT_ID   8'h02
`define ZPU_COMPAT_MAJOR 8'h01
`define ZPU_COMPAT_MINOR 16'h0003

`endif

//--- design/zpu_ctrl_pkg.sv
// Shared types of the control and status block
// Imported by every block that carries data words, addresses or SFP flags
`default_nettype none

`include "zpu_ctrl_cfg.svh"

package zpu_ctrl_pkg;

   // Settings and readback data word
   typedef logic [`ZPU_DW-1:0] word_t;

   // Register address on both buses
   typedef logic [`ZPU_SB_ADDRW-1:0] reg_addr_t;

   // Status pins of one SFP cage
   typedef struct packed {
      logic mod_abs;     // Module absent
      logic tx_fault;    // Transmitter fault
      logic rx_los;      // Receive loss of signal
   } sfp_flags_t;

endpackage

`default_nettype wire

//--- design/ctrl_bus_bridge.sv
// Host register port to settings bus writes and readback reads
// Every strobe is acknowledged exactly one cycle later
`timescale 1ns/1ps
`default_nettype none

module ctrl_bus_bridge (
   input  wire                       clk,
   input  wire                       rst,
   // Host register port
   input  wire                       host_stb_i,
   input  wire                       host_we_i,
   input  wire zpu_ctrl_pkg::reg_addr_t host_addr_i,
   input  wire zpu_ctrl_pkg::word_t  host_wdata_i,
   output logic                      host_ack_o,
   output zpu_ctrl_pkg::word_t       host_rdata_o,
   // Settings bus
   output logic                      set_stb_o,
   output zpu_ctrl_pkg::reg_addr_t   set_addr_o,
   output zpu_ctrl_pkg::word_t       set_data_o,
   // Readback bus
   output zpu_ctrl_pkg::reg_addr_t   rb_addr_o,
   output logic                      rb_rd_stb_o,
   input  wire zpu_ctrl_pkg::word_t  rb_data_i
);

   //------------------------------------------------------------
   // Acknowledge and settings write strobe
   //------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         host_ack_o <= 1'b0;
         set_stb_o  <= 1'b0;
      end else begin
         host_ack_o <= host_stb_i;               // One cycle after the request
         set_stb_o  <= host_stb_i & host_we_i;   // Pulses in the ack cycle
      end
   end

   // Address and data of the last write
   always_ff @(posedge clk) begin
      if (host_stb_i && host_we_i) begin
         set_addr_o <= host_addr_i;
         set_data_o <= host_wdata_i;
      end
   end

   //------------------------------------------------------------
   // Readback
   //------------------------------------------------------------
   assign rb_addr_o   = host_addr_i;               // Straight from the host
   assign rb_rd_stb_o = host_stb_i & ~host_we_i;   // Read strobe in the request cycle

   // Read word sampled at the edge that raises ack
   always_ff @(posedge clk) begin
      if (rb_rd_stb_o)
         host_rdata_o <= rb_data_i;   // Held until the next read
   end

   // Host waits for ack before its next request
   a_no_stb_during_ack : assert property (@(posedge clk) disable iff (rst)
      host_stb_i |-> !host_ack_o);

endmodule

`default_nettype wire

//--- design/zpu_setting_regs.sv
// Setting registers decoded from the settings bus
// Reset, LED, debug and SFP rate-select controls
`timescale 1ns/1ps
`default_nettype none

`include "zpu_ctrl_cfg.svh"

module zpu_setting_regs (
   input  wire                          clk,
   input  wire                          rst,
   // Settings bus
   input  wire                          set_stb_i,
   input  wire zpu_ctrl_pkg::reg_addr_t set_addr_i,
   input  wire zpu_ctrl_pkg::word_t     set_data_i,
   // Register outputs
   output logic [3:0]                   sw_rst_o,
   output logic [15:0]                  leds_o,
   output zpu_ctrl_pkg::word_t          debug_o,
   output logic [1:0]                   sfp0_rs_low_o,
   output logic [1:0]                   sfp1_rs_low_o
);

   import zpu_ctrl_pkg::*;

   word_t debug_q;   // Debug register ahead of the pin stage

   //------------------------------------------------------------
   // Address match keeping the low bits of each register
   //------------------------------------------------------------
   // sw_rst bit 0 resets the PHY, bit 1 the radio clock domain
   // sfpN_rs_low bit n drives RSn low when set
   always_ff @(posedge clk) begin
      if (rst) begin
         sw_rst_o      <= '0;
         leds_o        <= '0;
         debug_q       <= '0;
         sfp0_rs_low_o <= '0;
         sfp1_rs_low_o <= '0;
      end else if (set_stb_i) begin
         case (set_addr_i)
            `SR_ZPU_SW_RST:    sw_rst_o      <= set_data_i[3:0];
            `SR_ZPU_LEDS:      leds_o        <= set_data_i[15:0];   // Ethernet LEDs
            `SR_ZPU_DEBUG:     debug_q       <= set_data_i;
            `SR_ZPU_SFP_CTRL0: sfp0_rs_low_o <= set_data_i[1:0];
            `SR_ZPU_SFP_CTRL1: sfp1_rs_low_o <= set_data_i[1:0];
            default: ;                                             // Not ours
         endcase
      end
   end

   // Extra stage toward the logic analyzer pins
   always_ff @(posedge clk) begin
      if (rst)
         debug_o <= '0;
      else
         debug_o <= debug_q;
   end

   // Address must be clean whenever a write is strobed
   a_addr_known : assert property (@(posedge clk) disable iff (rst)
      set_stb_i |-> !$isunknown(set_addr_i));

endmodule

`default_nettype wire

//--- design/sfp_monitor.sv
// Status pin monitor for one SFP cage
// Two-stage synchronizer per flag and sticky change bits cleared on read
`timescale 1ns/1ps
`default_nettype none

module sfp_monitor (
   input  wire                           clk,
   input  wire                           rst,
   input  wire zpu_ctrl_pkg::sfp_flags_t pins_i,      // Raw cage pins
   input  wire                           clr_i,       // Status word read
   output zpu_ctrl_pkg::sfp_flags_t      flags_o,     // Synced levels
   output zpu_ctrl_pkg::sfp_flags_t      changed_o    // Sticky change bits
);

   import zpu_ctrl_pkg::*;

   sfp_flags_t sync1_q;     // First stage that may go metastable
   sfp_flags_t sync2_q;     // Second stage
   sfp_flags_t changed_q;

   //------------------------------------------------------------
   // Synchronizer
   //------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         sync1_q <= '0;
         sync2_q <= '0;
      end else begin
         sync1_q <= pins_i;
         sync2_q <= sync1_q;
      end
   end

   // Change bit sets as the second stage takes a new level
   always_ff @(posedge clk) begin
      if (rst)
         changed_q <= '0;
      else if (clr_i)
         changed_q <= '0;                             // Clear beats a new change
      else
         changed_q <= changed_q | (sync1_q ^ sync2_q);
   end

   assign flags_o   = sync2_q;
   assign changed_o = changed_q;

endmodule

`default_nettype wire

//--- design/pkt_counter.sv
// Packet counter for one Ethernet port
// Counts stream beats with tlast on receive and transmit, up to 2 per cycle
`timescale 1ns/1ps
`default_nettype none

module pkt_counter (
   input  wire                 clk,
   input  wire                 rst,
   // Receive stream tap
   input  wire                 rx_tlast_i,
   input  wire                 rx_tvalid_i,
   input  wire                 rx_tready_i,
   // Transmit stream tap
   input  wire                 tx_tlast_i,
   input  wire                 tx_tvalid_i,
   input  wire                 tx_tready_i,
   output zpu_ctrl_pkg::word_t count_o
);

   import zpu_ctrl_pkg::*;

   logic       rx_end;    // Last beat of a received packet
   logic       tx_end;    // Last beat of a sent packet
   logic [1:0] inc;       // 0, 1 or 2 per cycle
   word_t      count_q;

   assign rx_end = rx_tlast_i & rx_tvalid_i & rx_tready_i;   // Stalled beat not counted
   assign tx_end = tx_tlast_i & tx_tvalid_i & tx_tready_i;
   assign inc    = {1'b0, rx_end} + {1'b0, tx_end};

   always_ff @(posedge clk) begin
      if (rst)
         count_q <= '0;
      else
         count_q <= count_q + word_t'(inc);   // Wraps at 2^32
   end

   assign count_o = count_q;

endmodule

`default_nettype wire

//--- design/zpu_readback.sv
// Readback mux with the free-running software timer
// Decodes SFP status reads into clear pulses for the change flags
`timescale 1ns/1ps
`default_nettype none

`include "zpu_ctrl_cfg.svh"

module zpu_readback (
   input  wire                           clk,
   input  wire                           rst,
   // Readback bus
   input  wire zpu_ctrl_pkg::reg_addr_t  rb_addr_i,
   input  wire                           rb_rd_stb_i,
   // Status sources
   input  wire zpu_ctrl_pkg::sfp_flags_t sfp0_flags_i,
   input  wire zpu_ctrl_pkg::sfp_flags_t sfp0_changed_i,
   input  wire zpu_ctrl_pkg::sfp_flags_t sfp1_flags_i,
   input  wire zpu_ctrl_pkg::sfp_flags_t sfp1_changed_i,
   input  wire [15:0]                    gmii_status0_i,
   input  wire [15:0]                    gmii_status1_i,
   input  wire zpu_ctrl_pkg::word_t      eth0_count_i,
   input  wire zpu_ctrl_pkg::word_t      eth1_count_i,
   // Read word and clear-on-read pulses
   output zpu_ctrl_pkg::word_t           rb_data_o,
   output logic                          sfp0_clr_o,
   output logic                          sfp1_clr_o
);

   import zpu_ctrl_pkg::*;

   word_t timer_q;   // Software timer, one tick per clk

   always_ff @(posedge clk) begin
      if (rst)
         timer_q <= '0;
      else
         timer_q <= timer_q + word_t'(1);
   end

   //------------------------------------------------------------
   // Readback mux
   //------------------------------------------------------------
   // SFP word holds GMII status, 10 zero bits, change bits, levels
   always_comb begin
      case (rb_addr_i)
         `RB_ZPU_COMPAT:       rb_data_o = {`ZPU_PRODUCT_ID, `ZPU_COMPAT_MAJOR, `ZPU_COMPAT_MINOR};
         `RB_ZPU_COUNTER:      rb_data_o = timer_q;
         `RB_ZPU_SFP_STATUS0:  rb_data_o = {gmii_status0_i, 10'h0, sfp0_changed_i, sfp0_flags_i};
         `RB_ZPU_SFP_STATUS1:  rb_data_o = {gmii_status1_i, 10'h0, sfp1_changed_i, sfp1_flags_i};
         `RB_ZPU_ETH0_PKT_CNT: rb_data_o = eth0_count_i;
         `RB_ZPU_ETH1_PKT_CNT: rb_data_o = eth1_count_i;
         default:              rb_data_o = '0;   // Unused addresses
      endcase
   end

   // Clear in the strobe cycle while the word above still carries the old flags
   assign sfp0_clr_o = rb_rd_stb_i && (rb_addr_i == `RB_ZPU_SFP_STATUS0);
   assign sfp1_clr_o = rb_rd_stb_i && (rb_addr_i == `RB_ZPU_SFP_STATUS1);

endmodule

`default_nettype wire

//--- design/zpu_ctrl_top.sv
// Control and status block top level
// Host register port in place of the processor, SFP and Ethernet status taps
`timescale 1ns/1ps
`default_nettype none

module zpu_ctrl_top (
   input  wire                           clk,
   input  wire                           rst,
   // Host register port
   input  wire                           host_stb_i,
   input  wire                           host_we_i,
   input  wire zpu_ctrl_pkg::reg_addr_t  host_addr_i,
   input  wire zpu_ctrl_pkg::word_t      host_wdata_i,
   output logic                          host_ack_o,
   output zpu_ctrl_pkg::word_t           host_rdata_o,
   // SFP cage pins and GMII status words
   input  wire zpu_ctrl_pkg::sfp_flags_t sfp0_pins_i,
   input  wire zpu_ctrl_pkg::sfp_flags_t sfp1_pins_i,
   input  wire [15:0]                    gmii_status0_i,
   input  wire [15:0]                    gmii_status1_i,
   // Ethernet stream taps
   input  wire                           eth0_rx_tlast_i,
   input  wire                           eth0_rx_tvalid_i,
   input  wire                           eth0_rx_tready_i,
   input  wire                           eth0_tx_tlast_i,
   input  wire                           eth0_tx_tvalid_i,
   input  wire                           eth0_tx_tready_i,
   input  wire                           eth1_rx_tlast_i,
   input  wire                           eth1_rx_tvalid_i,
   input  wire                           eth1_rx_tready_i,
   input  wire                           eth1_tx_tlast_i,
   input  wire                           eth1_tx_tvalid_i,
   input  wire                           eth1_tx_tready_i,
   // Setting outputs with rate selects going to open-drain buffers on the board
   output logic [3:0]                    sw_rst_o,
   output logic [15:0]                   leds_o,
   output zpu_ctrl_pkg::word_t           debug_o,
   output logic [1:0]                    sfp0_rs_low_o,
   output logic [1:0]                    sfp1_rs_low_o
);

   import zpu_ctrl_pkg::*;

   logic       set_stb;        // Settings bus
   reg_addr_t  set_addr;
   word_t      set_data;
   reg_addr_t  rb_addr;        // Readback bus
   logic       rb_rd_stb;
   word_t      rb_data;
   sfp_flags_t sfp0_flags;
   sfp_flags_t sfp0_changed;
   sfp_flags_t sfp1_flags;
   sfp_flags_t sfp1_changed;
   logic       sfp0_clr;
   logic       sfp1_clr;
   word_t      eth0_count;
   word_t      eth1_count;

   //------------------------------------------------------------
   // Register access
   //------------------------------------------------------------
   ctrl_bus_bridge i_bridge (
      .clk(clk), .rst(rst),
      .host_stb_i(host_stb_i), .host_we_i(host_we_i), .host_addr_i(host_addr_i),
      .host_wdata_i(host_wdata_i), .host_ack_o(host_ack_o), .host_rdata_o(host_rdata_o),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data),
      .rb_addr_o(rb_addr), .rb_rd_stb_o(rb_rd_stb), .rb_data_i(rb_data)
   );

   zpu_setting_regs i_regs (
      .clk(clk), .rst(rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .sw_rst_o(sw_rst_o), .leds_o(leds_o), .debug_o(debug_o),
      .sfp0_rs_low_o(sfp0_rs_low_o), .sfp1_rs_low_o(sfp1_rs_low_o)
   );

   zpu_readback i_readback (
      .clk(clk), .rst(rst),
      .rb_addr_i(rb_addr), .rb_rd_stb_i(rb_rd_stb),
      .sfp0_flags_i(sfp0_flags), .sfp0_changed_i(sfp0_changed),
      .sfp1_flags_i(sfp1_flags), .sfp1_changed_i(sfp1_changed),
      .gmii_status0_i(gmii_status0_i), .gmii_status1_i(gmii_status1_i),
      .eth0_count_i(eth0_count), .eth1_count_i(eth1_count),
      .rb_data_o(rb_data), .sfp0_clr_o(sfp0_clr), .sfp1_clr_o(sfp1_clr)
   );

   //------------------------------------------------------------
   // Per-cage and per-port status
   //------------------------------------------------------------
   sfp_monitor i_sfp0 (
      .clk(clk), .rst(rst), .pins_i(sfp0_pins_i), .clr_i(sfp0_clr),
      .flags_o(sfp0_flags), .changed_o(sfp0_changed)
   );

   sfp_monitor i_sfp1 (
      .clk(clk), .rst(rst), .pins_i(sfp1_pins_i), .clr_i(sfp1_clr),
      .flags_o(sfp1_flags), .changed_o(sfp1_changed)
   );

   pkt_counter i_eth0_cnt (
      .clk(clk), .rst(rst),
      .rx_tlast_i(eth0_rx_tlast_i), .rx_tvalid_i(eth0_rx_tvalid_i), .rx_tready_i(eth0_rx_tready_i),
      .tx_tlast_i(eth0_tx_tlast_i), .tx_tvalid_i(eth0_tx_tvalid_i), .tx_tready_i(eth0_tx_tready_i),
      .count_o(eth0_count)
   );

   pkt_counter i_eth1_cnt (
      .clk(clk), .rst(rst),
      .rx_tlast_i(eth1_rx_tlast_i), .rx_tvalid_i(eth1_rx_tvalid_i), .rx_tready_i(eth1_rx_tready_i),
      .tx_tlast_i(eth1_tx_tlast_i), .tx_tvalid_i(eth1_tx_tvalid_i), .tx_tready_i(eth1_tx_tready_i),
      .count_o(eth1_count)
   );

endmodule

`default_nettype wire

//--- bench/tb_zpu_ctrl.sv
// Self-checking testbench of the control and status block
// Applies a table of register accesses, SFP pin changes and stream beats
`timescale 1ns/1ps
`default_nettype none

`include "zpu_ctrl_cfg.svh"

module tb_zpu_ctrl;

   localparam int CLK_PERIOD = 8;
   localparam int RST_CYCLES = 8;
   localparam int STEP_CYCLES = 20;   // Watchdog budget per table entry

   typedef enum logic [2:0] {OP_WR, OP_RD, OP_PIN, OP_BEAT, OP_WAIT} op_e;

   // One table entry
   typedef struct packed {
      op_e         op;
      logic [7:0]  addr;     // Register address, or cage / port number
      logic [31:0] wdata;    // Write data, pin levels, beat bits or wait cycles
      logic [31:0] want;     // Expected output or read word
   } step_t;

   logic        clk;
   logic        rst;
   logic        host_stb_i;
   logic        host_we_i;
   logic [7:0]  host_addr_i;
   logic [31:0] host_wdata_i;
   logic        host_ack_o;
   logic [31:0] host_rdata_o;
   logic [2:0]  sfp0_pins_i;
   logic [2:0]  sfp1_pins_i;
   logic [15:0] gmii_status0_i;
   logic [15:0] gmii_status1_i;
   logic [5:0]  eth0_tap;   // rx tlast, tvalid, tready, then tx
   logic [5:0]  eth1_tap;
   logic [3:0]  sw_rst_o;
   logic [15:0] leds_o;
   logic [31:0] debug_o;
   logic [1:0]  sfp0_rs_low_o;
   logic [1:0]  sfp1_rs_low_o;

   step_t       steps[$];
   bit          steps_ready = 1'b0;
   logic [31:0] lcg_state = 32'h3eeabdb0;
   int          checks = 0;
   int          errors = 0;
   time         stb_time;                // Time of the last host strobe
   logic [31:0] shadow [0:4];            // Expected setting outputs
   logic [2:0]  pin_level [0:1];         // Expected synced SFP levels
   logic [2:0]  pin_chg [0:1];           // Expected sticky change bits

   zpu_ctrl_top i_dut (
      .clk(clk), .rst(rst),
      .host_stb_i(host_stb_i), .host_we_i(host_we_i), .host_addr_i(host_addr_i),
      .host_wdata_i(host_wdata_i), .host_ack_o(host_ack_o), .host_rdata_o(host_rdata_o),
      .sfp0_pins_i(sfp0_pins_i), .sfp1_pins_i(sfp1_pins_i),
      .gmii_status0_i(gmii_status0_i), .gmii_status1_i(gmii_status1_i),
      .eth0_rx_tlast_i(eth0_tap[5]), .eth0_rx_tvalid_i(eth0_tap[4]),
      .eth0_rx_tready_i(eth0_tap[3]), .eth0_tx_tlast_i(eth0_tap[2]),
      .eth0_tx_tvalid_i(eth0_tap[1]), .eth0_tx_tready_i(eth0_tap[0]),
      .eth1_rx_tlast_i(eth1_tap[5]), .eth1_rx_tvalid_i(eth1_tap[4]),
      .eth1_rx_tready_i(eth1_tap[3]), .eth1_tx_tlast_i(eth1_tap[2]),
      .eth1_tx_tvalid_i(eth1_tap[1]), .eth1_tx_tready_i(eth1_tap[0]),
      .sw_rst_o(sw_rst_o), .leds_o(leds_o), .debug_o(debug_o),
      .sfp0_rs_low_o(sfp0_rs_low_o), .sfp1_rs_low_o(sfp1_rs_low_o)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   //------------------------------------------------------------
   // Helpers
   //------------------------------------------------------------
   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [31:0] setting_out(int k);
      case (k)
         0:       return 32'(sw_rst_o);
         1:       return 32'(leds_o);
         2:       return debug_o;
         3:       return 32'(sfp0_rs_low_o);
         default: return 32'(sfp1_rs_low_o);
      endcase
   endfunction

   task automatic check_value(input logic [31:0] got, input logic [31:0] want, input string msg);
      checks++;
      if (got !== want) begin
         errors++;
         $display("MISMATCH at %0t: %s, got %h expected %h", $time, msg, got, want);
      end
   endtask

   task automatic add_step(op_e op, logic [7:0] addr, logic [31:0] wdata, logic [31:0] want);
      step_t s;
      s.op    = op;
      s.addr  = addr;
      s.wdata = wdata;
      s.want  = want;
      steps.push_back(s);
   endtask

   // One register cycle that returns at the falling edge of the ack cycle
   task automatic host_access(input logic we, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
      int cycles;
      @(posedge clk);
      host_stb_i   <= 1'b1;
      host_we_i    <= we;
      host_addr_i  <= addr;
      host_wdata_i <= wdata;
      stb_time = $time;
      @(posedge clk);
      host_stb_i <= 1'b0;
      cycles = 1;
      @(negedge clk);
      while (!host_ack_o) begin   // Watchdog catches a missing ack
         @(negedge clk);
         cycles++;
      end
      check_value(32'(cycles), 32'd1, "ack latency");
      rdata = host_rdata_o;
   endtask

   task automatic set_pins(input logic port, input logic [2:0] level);
      @(posedge clk);
      if (port)
         sfp1_pins_i <= level;
      else
         sfp0_pins_i <= level;
      pin_chg[port]   = pin_chg[port] | (pin_level[port] ^ level);   // Sticky until read
      pin_level[port] = level;
   endtask

   // Single-cycle beat on one port's taps
   task automatic stream_beat(input logic port, input logic [5:0] bits);
      @(posedge clk);
      if (port)
         eth1_tap <= bits;
      else
         eth0_tap <= bits;
      @(posedge clk);
      eth0_tap <= '0;
      eth1_tap <= '0;
   endtask

   //------------------------------------------------------------
   // Stimulus table
   //------------------------------------------------------------
   task automatic build_steps();
      logic [31:0] r;
      // Reset values with the GMII field of SFP words taken from the model
      add_step(OP_RD, `RB_ZPU_COMPAT, 0, 32'h0201_0003);   // Product 02, major 01, minor 0003
      add_step(OP_RD, `RB_ZPU_ETH0_PKT_CNT, 0, 0);
      add_step(OP_RD, `RB_ZPU_ETH1_PKT_CNT, 0, 0);
      add_step(OP_RD, `RB_ZPU_SFP_STATUS0, 0, 0);
      add_step(OP_RD, `RB_ZPU_SFP_STATUS1, 0, 0);
      add_step(OP_RD, 8'd4, 0, 0);
      add_step(OP_RD, 8'd7, 0, 0);
      // Setting writes truncated to each width
      add_step(OP_WR, `SR_ZPU_SW_RST, 32'hffff_fffa, 32'h0000_000a);
      add_step(OP_WR, `SR_ZPU_LEDS, 32'h1234_abcd, 32'h0000_abcd);
      r = next_rand();
      add_step(OP_WR, `SR_ZPU_DEBUG, r, r);
      add_step(OP_WR, `SR_ZPU_SFP_CTRL0, 32'h0000_0007, 32'h0000_0003);
      add_step(OP_WR, `SR_ZPU_SFP_CTRL1, 32'hffff_fffe, 32'h0000_0002);
      add_step(OP_WR, 8'h09, next_rand(), 0);                 // Unused address
      r = next_rand();
      add_step(OP_WR, `SR_ZPU_DEBUG, r, r);
      // SFP pin changes where the second read sees cleared change bits
      add_step(OP_PIN, 8'd0, 32'b101, 0);
      add_step(OP_WAIT, 0, 3, 0);
      add_step(OP_RD, `RB_ZPU_SFP_STATUS0, 0, 0);
      add_step(OP_RD, `RB_ZPU_SFP_STATUS0, 0, 0);
      add_step(OP_PIN, 8'd1, 32'b010, 0);
      add_step(OP_WAIT, 0, 4, 0);
      add_step(OP_RD, `RB_ZPU_SFP_STATUS0, 0, 0);
      add_step(OP_RD, `RB_ZPU_SFP_STATUS1, 0, 0);
      add_step(OP_RD, `RB_ZPU_SFP_STATUS1, 0, 0);
      add_step(OP_PIN, 8'd0, 32'b001, 0);
      add_step(OP_WAIT, 0, 3, 0);
      add_step(OP_RD, `RB_ZPU_SFP_STATUS0, 0, 0);
      add_step(OP_RD, `RB_ZPU_SFP_STATUS0, 0, 0);
      // Packet counters
      add_step(OP_BEAT, 8'd0, 32'b111_000, 0);                // Receive end
      add_step(OP_RD, `RB_ZPU_ETH0_PKT_CNT, 0, 1);
      add_step(OP_RD, `RB_ZPU_ETH1_PKT_CNT, 0, 0);
      add_step(OP_BEAT, 8'd0, 32'b000_111, 0);                // Transmit end
      add_step(OP_RD, `RB_ZPU_ETH0_PKT_CNT, 0, 2);
      add_step(OP_BEAT, 8'd0, 32'b111_111, 0);                // Both at once
      add_step(OP_RD, `RB_ZPU_ETH0_PKT_CNT, 0, 4);
      add_step(OP_BEAT, 8'd0, 32'b011_110, 0);                // No tlast and tready low
      add_step(OP_RD, `RB_ZPU_ETH0_PKT_CNT, 0, 4);
      add_step(OP_BEAT, 8'd1, 32'b111_111, 0);
      add_step(OP_BEAT, 8'd1, 32'b000_111, 0);
      add_step(OP_RD, `RB_ZPU_ETH1_PKT_CNT, 0, 3);
      add_step(OP_RD, `RB_ZPU_ETH0_PKT_CNT, 0, 4);
      // Timer steps between strobes
      add_step(OP_RD, `RB_ZPU_COUNTER, 0, 0);
      add_step(OP_WAIT, 0, 13, 0);
      add_step(OP_RD, `RB_ZPU_COUNTER, 0, 0);
      add_step(OP_RD, `RB_ZPU_COUNTER, 0, 0);
   endtask

   //------------------------------------------------------------
   // Main sequence
   //------------------------------------------------------------
   initial begin
      step_t       s;
      logic [31:0] rdata;
      logic [31:0] want;
      logic [31:0] old_debug;
      logic [31:0] last_timer;
      time         last_timer_time;
      bit          have_timer;
      logic        port;
      have_timer = 1'b0;
      rst          <= 1'b1;
      host_stb_i   <= 1'b0;
      host_we_i    <= 1'b0;
      host_addr_i  <= '0;
      host_wdata_i <= '0;
      sfp0_pins_i  <= '0;
      sfp1_pins_i  <= '0;
      eth0_tap     <= '0;
      eth1_tap     <= '0;
      rdata = next_rand();
      gmii_status0_i <= rdata[15:0];
      rdata = next_rand();
      gmii_status1_i <= rdata[31:16];
      for (int k = 0; k < 5; k++) shadow[k] = '0;
      for (int k = 0; k < 2; k++) begin
         pin_level[k] = '0;
         pin_chg[k]   = '0;
      end
      build_steps();
      steps_ready = 1'b1;

      repeat (RST_CYCLES) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      for (int k = 0; k < 5; k++) check_value(setting_out(k), 32'h0, "setting after reset");
      check_value(32'(host_ack_o), 32'h0, "ack after reset");

      foreach (steps[i]) begin
         s = steps[i];
         case (s.op)
            OP_WR: begin
               host_access(1'b1, s.addr, s.wdata, rdata);
               for (int k = 0; k < 5; k++)                  // Strobe plus 1
                  check_value(setting_out(k), shadow[k], "setting output before update");
               old_debug = shadow[2];
               if (s.addr < 8'd5) shadow[s.addr[2:0]] = s.want;
               @(negedge clk);                              // Strobe plus 2
               for (int k = 0; k < 5; k++)
                  if (k != 2) check_value(setting_out(k), shadow[k], "setting output");
               check_value(debug_o, old_debug, "debug_o ahead of its pin stage");
               @(negedge clk);                              // Strobe plus 3
               check_value(debug_o, shadow[2], "debug_o");
            end
            OP_RD: begin
               host_access(1'b0, s.addr, 32'h0, rdata);
               if (s.addr == `RB_ZPU_COUNTER) begin
                  if (have_timer)
                     check_value(rdata - last_timer,
                                 32'((stb_time - last_timer_time) / CLK_PERIOD), "timer step");
                  have_timer      = 1'b1;
                  last_timer      = rdata;
                  last_timer_time = stb_time;
               end else if (s.addr == `RB_ZPU_SFP_STATUS0 || s.addr == `RB_ZPU_SFP_STATUS1) begin
                  port = (s.addr == `RB_ZPU_SFP_STATUS1);
                  want = {port ? gmii_status1_i : gmii_status0_i, 10'h0,
                          pin_chg[port], pin_level[port]};
                  check_value(rdata, want, $sformatf("SFP status %0d", port));
                  pin_chg[port] = '0;                       // Cleared by the read
               end else begin
                  check_value(rdata, s.want, $sformatf("read of address %0d", s.addr));
               end
            end
            OP_PIN:  set_pins(s.addr[0], s.wdata[2:0]);
            OP_BEAT: stream_beat(s.addr[0], s.wdata[5:0]);
            OP_WAIT: repeat (s.wdata) @(posedge clk);
            default: begin
               errors++;
               $display("Table entry %0d has an unknown operation", i);
            end
         endcase
      end

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

   // Watchdog sized from the table length
   initial begin
      int limit;
      wait (steps_ready);
      limit = steps.size() * STEP_CYCLES + RST_CYCLES;
      repeat (limit) @(posedge clk);
      $display("Timeout: run did not finish within %0d cycles", limit);
      $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

//--- sources.f
+incdir+design
design/zpu_ctrl_pkg.sv
design/ctrl_bus_bridge.sv
design/zpu_setting_regs.sv
design/sfp_monitor.sv
design/pkt_counter.sv
design/zpu_readback.sv
design/zpu_ctrl_top.sv
bench/tb_zpu_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the control block testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f sources.f --top-module tb_zpu_ctrl -o tb_zpu_ctrl
./obj_dir/tb_zpu_ctrl > sim.log
cat sim.log
if grep -q '^\*\* PASS \*\*$' sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed, see sim.log"
   exit 1
fi
